// ==== rtl/mapperPkg.sv ====
`default_nettype none

package mapperPkg;

	localparam int ScreenW = 640;
	localparam int ScreenH = 480;
	localparam int CoordW = 11;
	localparam int CamW = 13;

	// World map, one cell per 4x4 world pixels
	localparam int MapCols = 320;
	localparam int MapRows = 240;
	localparam int TileShift = 2;
	localparam int MapDepth = MapCols * MapRows;
	localparam int MapAddrW = $clog2(MapDepth);

	// Character window on screen
	localparam logic [CoordW-1:0] SpriteX0 = 11'd311;
	localparam logic [CoordW-1:0] SpriteY0 = 11'd340;
	localparam logic [CoordW-1:0] SpriteW = 11'd19;
	localparam logic [CoordW-1:0] SpriteH = 11'd29;
	localparam int SheetW = 228;
	localparam int SheetDepth = SheetW * 29;
	localparam int SheetAddrW = $clog2(SheetDepth);

	localparam logic signed [CamW-1:0] StartX = 13'sd100;
	localparam logic signed [CamW-1:0] StartY = 13'sd100;
	localparam int CamMinX = -311;
	localparam int CamMaxX = 951;
	localparam int CamMinY = -340;
	localparam int CamMaxY = 594;

	localparam logic [7:0] StartKey = 8'h2C;
	localparam int StepDiv = 8;

	typedef enum logic [1:0] {Up = 2'd0, Right = 2'd1, Down = 2'd2, Left = 2'd3} facing_e;
	typedef enum logic [1:0] {Rest1, Move1, Rest2, Move2} frame_e;
	typedef enum logic {Start, Overworld} gameState_e;

	// Sheet column per facing, in order Up, Right, Down, Left
	localparam logic [7:0] FacingBase [4] = '{8'd114, 8'd171, 8'd0, 8'd57};
	// Column offset per frame, in order Rest1, Move1, Rest2, Move2
	localparam logic [7:0] FrameOffset [4] = '{8'd19, 8'd0, 8'd19, 8'd38};

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// Entry 0 is transparent
	localparam rgb_t SpritePalette [16] = '{
		24'h000000, 24'hf8f8f8, 24'h181010, 24'he8b080,
		24'hc07848, 24'h783818, 24'hd02818, 24'h801008,
		24'h3858c8, 24'h182878, 24'h58a040, 24'h286020,
		24'hf0d040, 24'h989898, 24'h585858, 24'hf8a8b8
	};
	localparam rgb_t StartColor = 24'h2050a0;

	typedef struct packed {
		logic [CoordW-1:0] drawX;
		logic [CoordW-1:0] drawY;
		logic visible;
	} scanPos_t;

	typedef struct packed {
		logic moving;
		facing_e direction;
	} padIn_t;

	typedef struct packed {
		logic en;
		logic toMap;
		logic [MapAddrW-1:0] addr;
		logic [7:0] data;
	} memWrite_t;

	typedef struct packed {
		logic signed [CamW-1:0] camX;
		logic signed [CamW-1:0] camY;
		facing_e facing;
		frame_e frame;
		gameState_e gameState;
	} viewState_t;

	typedef struct packed {
		logic visible;
		logic offMap;
		logic inWindow;
	} stage1_t;

	// Map index is RRRGGGBB, each field replicated up to 8 bits
	function automatic rgb_t mapColor(input logic [7:0] idx);
		rgb_t c;
		c.red = {idx[7:5], idx[7:5], idx[7:6]};
		c.green = {idx[4:2], idx[4:2], idx[4:3]};
		c.blue = {idx[1:0], idx[1:0], idx[1:0], idx[1:0]};
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/textureRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module textureRam #(
	parameter int Depth = 1024,
	parameter int Width = 8
) (
	input logic Clk,
	input logic we,
	input logic [$clog2(Depth)-1:0] waddr,
	input logic [$clog2(Depth)-1:0] raddr,
	input logic [Width-1:0] wdata,
	output logic [Width-1:0] rdata
);

	logic [Width-1:0] mem [Depth];

	always_ff @(posedge Clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== rtl/overworldState.sv ====
`timescale 1ns/1ps
`default_nettype none

module overworldState import mapperPkg::*; (
	input logic Clk,
	input logic rst,
	input logic frameTick,
	input logic [7:0] keycode,
	input facing_e facing,
	input frame_e frame,
	input logic stepReq,
	output logic advance,
	output viewState_t view
);

	gameState_e state;
	logic signed [CamW-1:0] camX, camY;

	// Walk logic only runs in the overworld
	assign advance = frameTick && (state == Overworld);

	always_ff @(posedge Clk) begin
		if (rst) begin
			state <= Start;
			camX <= StartX;
			camY <= StartY;
		end else if (frameTick && state == Start) begin
			if (keycode == StartKey) begin
				state <= Overworld;
				camX <= StartX;
				camY <= StartY;
			end
		end else if (stepReq) begin
			case (facing)
				Up: if (camY > CamMinY) camY <= camY - CamW'(1);
				Down: if (camY <= CamMaxY) camY <= camY + CamW'(1);
				Left: if (camX > CamMinX) camX <= camX - CamW'(1);
				Right: if (camX <= CamMaxX) camX <= camX + CamW'(1);
				default: ;
			endcase
		end
	end

	assign view = '{camX: camX, camY: camY, facing: facing, frame: frame, gameState: state};

endmodule

`default_nettype wire

// ==== rtl/walkAnimator.sv ====
`timescale 1ns/1ps
`default_nettype none

module walkAnimator import mapperPkg::*; (
	input logic Clk,
	input logic rst,
	input logic advance,
	input padIn_t pad,
	output facing_e facing,
	output frame_e frame,
	output logic stepReq
);

	localparam int DelayW = $clog2(StepDiv);

	logic [DelayW-1:0] delay;
	logic walking;
	frame_e nextFrame;

	// Pressing toward the current facing is a real step
	assign walking = pad.moving && (pad.direction == facing);
	assign stepReq = advance && walking;

	always_comb begin
		case (frame)
			Rest1: nextFrame = Move1;
			Move1: nextFrame = Rest2;
			Rest2: nextFrame = Move2;
			default: nextFrame = Rest1;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			facing <= Up;
			frame <= Rest1;
			delay <= '0;
		end else if (advance) begin
			if (!pad.moving) begin
				frame <= Rest1;
			end else if (!walking) begin
				// Turn in place, no step taken
				facing <= pad.direction;
				frame <= Rest1;
			end else begin
				if (delay == DelayW'(StepDiv - 1)) begin
					delay <= '0;
				end else begin
					delay <= delay + 1'b1;
				end
				// Frame only changes on the first tick of each delay period
				if (delay == '0) begin
					frame <= nextFrame;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/addressGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module addressGen import mapperPkg::*; (
	input logic Clk,
	input logic rst,
	input scanPos_t scan,
	input viewState_t view,
	output logic [MapAddrW-1:0] mapAddr,
	output logic [SheetAddrW-1:0] sheetAddr,
	output stage1_t stage1
);

	logic signed [CamW:0] worldX, worldY;
	logic [CamW-TileShift-1:0] cellX, cellY;
	logic [CoordW-1:0] colOff, rowOff;
	logic offMap, inWindow;

	assign worldX = $signed(CamW'(scan.drawX)) + view.camX;
	assign worldY = $signed(CamW'(scan.drawY)) + view.camY;

	// Drop the sign bit, it is tested separately
	assign cellX = worldX[CamW-1:TileShift];
	assign cellY = worldY[CamW-1:TileShift];

	assign offMap = worldX[CamW] || worldY[CamW]
		|| int'(cellX) >= MapCols || int'(cellY) >= MapRows;

	assign mapAddr = offMap ? '0
		: MapAddrW'(cellY) * MapAddrW'(MapCols) + MapAddrW'(cellX);

	assign inWindow = scan.drawX >= SpriteX0 && scan.drawX < SpriteX0 + SpriteW
		&& scan.drawY >= SpriteY0 && scan.drawY < SpriteY0 + SpriteH;

	assign colOff = scan.drawX - SpriteX0;
	assign rowOff = scan.drawY - SpriteY0;

	// Frame picked by facing base plus walk-cycle offset
	assign sheetAddr = !inWindow ? '0
		: SheetAddrW'(SheetW) * SheetAddrW'(rowOff) + SheetAddrW'(colOff)
		+ SheetAddrW'(FacingBase[view.facing]) + SheetAddrW'(FrameOffset[view.frame]);

	always_ff @(posedge Clk) begin
		if (rst) begin
			stage1 <= '0;
		end else begin
			stage1 <= '{visible: scan.visible, offMap: offMap, inWindow: inWindow};
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pixelColor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelColor import mapperPkg::*; (
	input logic Clk,
	input logic rst,
	input stage1_t stage1,
	input gameState_e gameState,
	input logic [7:0] mapIndex,
	input logic [3:0] spriteIndex,
	output rgb_t rgb
);

	gameState_e stateQ;
	rgb_t nextRgb;

	// Lines the state up with the pixel now leaving the RAMs
	always_ff @(posedge Clk) begin
		if (rst) begin
			stateQ <= Start;
		end else begin
			stateQ <= gameState;
		end
	end

	always_comb begin
		if (!stage1.visible) begin
			nextRgb = '0;
		end else if (stateQ == Start) begin
			nextRgb = StartColor;
		end else if (stage1.offMap) begin
			nextRgb = '0;
		end else if (stage1.inWindow && spriteIndex != 4'd0) begin
			nextRgb = SpritePalette[spriteIndex];
		end else begin
			nextRgb = mapColor(mapIndex);
		end
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			rgb <= '0;
		end else begin
			rgb <= nextRgb;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/colorMapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module colorMapper import mapperPkg::*; (
	input logic Clk,
	input logic rst,
	input logic frameTick,
	input logic [7:0] keycode,
	input padIn_t pad,
	input scanPos_t scan,
	input memWrite_t load,
	output rgb_t rgb
);

	viewState_t view;
	facing_e facing;
	frame_e frame;
	logic stepReq;
	logic advance;
	logic [MapAddrW-1:0] mapAddr;
	logic [SheetAddrW-1:0] sheetAddr;
	stage1_t stage1;
	logic [7:0] mapIndex;
	logic [3:0] spriteIndex;

	overworldState state (
		.Clk(Clk),
		.rst(rst),
		.frameTick(frameTick),
		.keycode(keycode),
		.facing(facing),
		.frame(frame),
		.stepReq(stepReq),
		.advance(advance),
		.view(view)
	);

	walkAnimator anim (
		.Clk(Clk),
		.rst(rst),
		.advance(advance),
		.pad(pad),
		.facing(facing),
		.frame(frame),
		.stepReq(stepReq)
	);

	addressGen addr (
		.Clk(Clk),
		.rst(rst),
		.scan(scan),
		.view(view),
		.mapAddr(mapAddr),
		.sheetAddr(sheetAddr),
		.stage1(stage1)
	);

	// toMap steers the load port to one RAM
	textureRam #(.Depth(MapDepth), .Width(8)) mapRam (
		.Clk(Clk),
		.we(load.en && load.toMap),
		.waddr(load.addr),
		.raddr(mapAddr),
		.wdata(load.data),
		.rdata(mapIndex)
	);

	textureRam #(.Depth(SheetDepth), .Width(4)) sheetRam (
		.Clk(Clk),
		.we(load.en && !load.toMap),
		.waddr(load.addr[SheetAddrW-1:0]),
		.raddr(sheetAddr),
		.wdata(load.data[3:0]),
		.rdata(spriteIndex)
	);

	pixelColor color (
		.Clk(Clk),
		.rst(rst),
		.stage1(stage1),
		.gameState(view.gameState),
		.mapIndex(mapIndex),
		.spriteIndex(spriteIndex),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// ==== tests/colorMapper_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module colorMapperAsserts import mapperPkg::*; (
	input logic Clk,
	input logic rst,
	input logic frameTick,
	input scanPos_t scan,
	input rgb_t rgb,
	input viewState_t view
);

	int failures = 0;

	// Blanking has the same two-cycle latency as any pixel
	blankInvisible: assert property (@(posedge Clk) disable iff (rst)
		!scan.visible |-> ##2 rgb == '0)
	else begin
		failures++;
		$error("rgb not black two cycles after an invisible scan");
	end

	frameOnTick: assert property (@(posedge Clk) disable iff (rst)
		view.frame != $past(view.frame) |-> $past(frameTick))
	else begin
		failures++;
		$error("walk frame changed without a frame tick");
	end

endmodule

bind colorMapper colorMapperAsserts asserts (
	.Clk(Clk),
	.rst(rst),
	.frameTick(frameTick),
	.scan(scan),
	.rgb(rgb),
	.view(view)
);

`default_nettype wire

// ==== tests/colorMapperTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module colorMapperTb import mapperPkg::*; ();

	typedef struct packed {
		logic valid;
		scanPos_t pos;
		rgb_t color;
	} pixelTag_t;

	// Image load takes about 83k cycles and the tests under 10k
	localparam int CycleLimit = 200000;

	logic Clk;
	logic rst;
	logic frameTick;
	logic [7:0] keycode;
	padIn_t pad;
	scanPos_t scan;
	memWrite_t load;
	rgb_t rgb;

	logic [15:0] lfsr;
	logic [7:0] mapModel [MapDepth];
	logic [3:0] sheetModel [SheetDepth];
	gameState_e mState;
	facing_e mFacing;
	frame_e mFrame;
	int mCamX, mCamY, mDelay;
	pixelTag_t drvTag, tag1, tag2;
	int cycles, checkCount, errCount, testsRun, testsFailed, testErrStart, assertFails;

	colorMapper dut (
		.Clk(Clk),
		.rst(rst),
		.frameTick(frameTick),
		.keycode(keycode),
		.pad(pad),
		.scan(scan),
		.load(load),
		.rgb(rgb)
	);

	always #2 Clk = ~Clk;

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randBits(input int n, output int v);
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsrNext(lfsr);
		end
	endtask

	function automatic rgb_t mapRgb(input logic [7:0] idx);
		rgb_t c;
		// 3-bit fields scale by 73/2 and the 2-bit blue by 85
		c.red = 8'((int'(idx[7:5]) * 73) >> 1);
		c.green = 8'((int'(idx[4:2]) * 73) >> 1);
		c.blue = 8'(int'(idx[1:0]) * 85);
		return c;
	endfunction

	function automatic rgb_t expectedColor(input scanPos_t s);
		int x, y, wx, wy, sheetIdx;
		logic [3:0] spr;
		x = int'(s.drawX);
		y = int'(s.drawY);
		wx = x + mCamX;
		wy = y + mCamY;
		if (!s.visible) begin
			return '0;
		end
		if (mState == Start) begin
			return StartColor;
		end
		if (wx < 0 || wy < 0 || wx / 4 >= MapCols || wy / 4 >= MapRows) begin
			return '0;
		end
		if (x >= int'(SpriteX0) && x < int'(SpriteX0) + int'(SpriteW)
				&& y >= int'(SpriteY0) && y < int'(SpriteY0) + int'(SpriteH)) begin
			sheetIdx = SheetW * (y - int'(SpriteY0)) + (x - int'(SpriteX0))
				+ int'(FacingBase[mFacing]) + int'(FrameOffset[mFrame]);
			spr = sheetModel[sheetIdx];
			if (spr != 4'd0) begin
				return SpritePalette[spr];
			end
		end
		return mapRgb(mapModel[(wy / 4) * MapCols + wx / 4]);
	endfunction

	function automatic viewState_t modelView();
		viewState_t v;
		v.camX = CamW'(mCamX);
		v.camY = CamW'(mCamY);
		v.facing = mFacing;
		v.frame = mFrame;
		v.gameState = mState;
		return v;
	endfunction

	function automatic string formatView(input viewState_t v);
		return $sformatf("cam (%0d,%0d) facing %0d frame %0d state %0d",
			v.camX, v.camY, v.facing, v.frame, v.gameState);
	endfunction

	task automatic checkRgb(input rgb_t got, input rgb_t exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("FAIL t=%0t %s: rgb %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkView(input viewState_t got, input viewState_t exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("FAIL t=%0t %s: %s, expected %s", $time, what,
				formatView(got), formatView(exp));
		end
	endtask

	task automatic loadImages();
		int i, v;
		for (i = 0; i < MapDepth; i++) begin
			randBits(8, v);
			mapModel[i] = 8'(v);
			load = '{en: 1'b1, toMap: 1'b1, addr: MapAddrW'(i), data: 8'(v)};
			@(negedge Clk);
		end
		for (i = 0; i < SheetDepth; i++) begin
			randBits(4, v);
			sheetModel[i] = 4'(v);
			load = '{en: 1'b1, toMap: 1'b0, addr: MapAddrW'(i), data: {4'd0, 4'(v)}};
			@(negedge Clk);
		end
		load = '0;
	endtask

	task automatic stepModel(input logic [7:0] key, input logic moving, input facing_e dir);
		if (mState == Start) begin
			if (key == StartKey) begin
				mState = Overworld;
				mCamX = 100;
				mCamY = 100;
			end
		end else if (!moving) begin
			mFrame = Rest1;
		end else if (dir != mFacing) begin
			mFacing = dir;
			mFrame = Rest1;
		end else begin
			case (mFacing)
				Up: if (mCamY > CamMinY) mCamY--;
				Down: if (mCamY <= CamMaxY) mCamY++;
				Left: if (mCamX > CamMinX) mCamX--;
				default: if (mCamX <= CamMaxX) mCamX++;
			endcase
			if (mDelay == 0) begin
				mFrame = frame_e'((int'(mFrame) + 1) % 4);
			end
			mDelay = (mDelay + 1) % StepDiv;
		end
	endtask

	task automatic frameStep(input logic [7:0] key, input logic moving, input facing_e dir);
		frameTick = 1'b1;
		keycode = key;
		pad = '{moving: moving, direction: dir};
		@(negedge Clk);
		frameTick = 1'b0;
		stepModel(key, moving, dir);
		checkView(dut.view, modelView(), "view after tick");
	endtask

	task automatic drivePixel(input int x, input int y, input logic vis);
		scan = '{drawX: CoordW'(x), drawY: CoordW'(y), visible: vis};
		drvTag = '{valid: 1'b1, pos: scan, color: expectedColor(scan)};
		@(negedge Clk);
	endtask

	task automatic sweepRow(input int y, input int x0, input int x1);
		int x;
		for (x = x0; x <= x1; x++) begin
			drivePixel(x, y, 1'b1);
		end
	endtask

	// Character window plus a small margin
	task automatic sweepWindow();
		int y;
		for (y = int'(SpriteY0) - 1; y <= int'(SpriteY0) + int'(SpriteH); y++) begin
			sweepRow(y, int'(SpriteX0) - 2, int'(SpriteX0) + int'(SpriteW) + 1);
		end
	endtask

	task automatic drainPipe();
		drvTag.valid = 1'b0;
		repeat (3) @(negedge Clk);
	endtask

	task automatic startTest();
		testErrStart = errCount;
	endtask

	task automatic endTest(input string name);
		drainPipe();
		testsRun++;
		if (errCount > testErrStart) begin
			testsFailed++;
			$display("Test %0d %s: %0d errors", testsRun, name, errCount - testErrStart);
		end else begin
			$display("Test %0d %s: ok", testsRun, name);
		end
	endtask

	// Expected color rides along with the pixel through two stages
	always @(posedge Clk) begin
		if (rst) begin
			tag1 <= '0;
			tag2 <= '0;
		end else begin
			tag1 <= drvTag;
			tag2 <= tag1;
		end
	end

	always @(negedge Clk) begin
		if (tag2.valid) begin
			checkRgb(rgb, tag2.color,
				$sformatf("pixel x=%0d y=%0d", tag2.pos.drawX, tag2.pos.drawY));
		end
	end

	always @(posedge Clk) begin
		cycles++;
		if (cycles >= CycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", CycleLimit);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		int i, x, y, v;
		Clk = 1'b0;
		rst = 1'b1;
		frameTick = 1'b0;
		keycode = '0;
		pad = '0;
		scan = '0;
		load = '0;
		drvTag = '0;
		lfsr = 16'd25;
		mState = Start;
		mFacing = Up;
		mFrame = Rest1;
		mCamX = 100;
		mCamY = 100;
		mDelay = 0;
		cycles = 0;
		checkCount = 0;
		errCount = 0;
		testsRun = 0;
		testsFailed = 0;
		repeat (8) @(negedge Clk);
		rst = 1'b0;
		checkRgb(rgb, '0, "rgb after reset");
		checkView(dut.view, modelView(), "view after reset");
		loadImages();

		startTest();
		for (i = 0; i < 300; i++) begin
			randBits(10, v);
			x = v % ScreenW;
			randBits(9, v);
			y = v % ScreenH;
			randBits(1, v);
			drivePixel(x, y, v[0]);
		end
		drainPipe();
		frameStep(8'h1C, 1'b0, Up);
		sweepRow(200, 0, 63);
		endTest("start screen");

		startTest();
		frameStep(StartKey, 1'b0, Up);
		sweepRow(20, 0, ScreenW - 1);
		sweepRow(ScreenH - 1, 0, ScreenW - 1);
		endTest("enter overworld");

		startTest();
		sweepWindow();
		endTest("sprite window up rest1");

		startTest();
		repeat (16) frameStep(8'h00, 1'b1, Up);
		sweepWindow();
		endTest("walk up 16 ticks");

		startTest();
		frameStep(8'h00, 1'b1, Right);
		frameStep(8'h00, 1'b1, Right);
		frameStep(8'h00, 1'b0, Right);
		sweepWindow();
		endTest("turn and release");

		startTest();
		frameStep(8'h00, 1'b1, Left);
		repeat (420) frameStep(8'h00, 1'b1, Left);
		sweepRow(20, 0, ScreenW - 1);
		sweepWindow();
		endTest("left camera limit");

		assertFails = dut.asserts.failures;
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			testsRun, testsFailed, checkCount, errCount, assertFails);
		if (errCount == 0 && assertFails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/mapperPkg.sv
rtl/textureRam.sv
rtl/overworldState.sv
rtl/walkAnimator.sv
rtl/addressGen.sv
rtl/pixelColor.sv
rtl/colorMapper.sv
tests/colorMapper_asserts.sv
tests/colorMapperTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= colorMapperTb
RTL_TOP ?= colorMapper
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
SIMARGS ?= +verilator+error+limit+100

SRCS = $(shell grep -v '^+' $(FILELIST))
RTL_SRCS = $(shell grep '^rtl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIMARGS) | tee $(LOG)
	grep -q '^Testbench passed$$' $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
